// ==== design/spi_pkg.sv ====
//////////////////////////////////////////////////
// Shared widths and types for the SPI master.
// Referenced by scoped name from each RTL block.
//////////////////////////////////////////////////
`default_nettype none

package spi_pkg;

  localparam int BYTE_W     = 8;              // Data byte
  localparam int LEN_BITS   = 11;             // Byte-count fields
  localparam int WAIT_BITS  = 2;              // Wait-cycle field
  localparam int GUARD_CYC  = 4;              // SCK periods per chip-select guard
  localparam int TIMER_BITS = LEN_BITS + 3;   // Holds 8x the largest byte count

  // Command as issued by the system and as held for the frame
  typedef struct packed {
    logic [LEN_BITS-1:0]  tx_len;    // Bytes to shift out, at least 1
    logic [WAIT_BITS-1:0] wait_cyc;  // Idle SCK periods before RX
    logic [LEN_BITS-1:0]  rx_len;    // Bytes to shift in
  } spi_cmd_t;

  // Bus outputs
  typedef struct packed {
    logic sck;
    logic csn;   // Active low
    logic copi;
  } spi_pins_t;

  // Frame states, all 8 codes used
  typedef enum logic [2:0] {
    IDLE, START_D, START_S, TX, WAIT, RX, STOP_S, STOP_D
  } spi_state_e;

endpackage : spi_pkg

`default_nettype wire

// ==== design/sync_fifo.sv ====
//////////////////////////////////////////////////
// Single-clock byte FIFO with registered read data.
// o_rd_valid marks the cycle after an accepted read.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter int FIFO_DEPTH = 2048  // Power of two
) (
  input  logic                       i_ext_spi_clk_x,
  input  logic                       i_srst,
  input  logic                       i_wr,
  input  logic [spi_pkg::BYTE_W-1:0] i_wr_data,
  input  logic                       i_rd,
  output logic [spi_pkg::BYTE_W-1:0] o_rd_data,
  output logic                       o_rd_valid,
  output logic                       o_full,
  output logic                       o_empty
);

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic [spi_pkg::BYTE_W-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0]              r_wr_ptr;  // Wraps naturally at FIFO_DEPTH
  logic [AW-1:0]              r_rd_ptr;
  logic [CW-1:0]              r_count;
  logic                       w_wr_ok;
  logic                       w_rd_ok;

  assign o_full  = (r_count == CW'(FIFO_DEPTH));
  assign o_empty = (r_count == '0);
  assign w_wr_ok = i_wr & ~o_full;   // Write while full is dropped
  assign w_rd_ok = i_rd & ~o_empty;  // Read while empty is dropped

  // Pointers, occupancy and read strobe
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      r_wr_ptr   <= '0;
      r_rd_ptr   <= '0;
      r_count    <= '0;
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= w_rd_ok;
      if (w_wr_ok) r_wr_ptr <= r_wr_ptr + 1'b1;
      if (w_rd_ok) r_rd_ptr <= r_rd_ptr + 1'b1;
      case ({w_wr_ok, w_rd_ok})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;  // Both or neither
      endcase
    end
  end

  // Storage and read register
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (w_wr_ok) mem[r_wr_ptr] <= i_wr_data;
    if (w_rd_ok) o_rd_data <= mem[r_rd_ptr];  // Held until the next read
  end

  a_no_wr_full : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    i_wr |-> !o_full) else $error("FIFO write while full");

  a_no_rd_empty : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    i_rd |-> !o_empty) else $error("FIFO read while empty");

endmodule : sync_fifo

`default_nettype wire

// ==== design/spi_phase_gen.sv ====
//////////////////////////////////////////////////
// SCK level and edge strobes from the system clock.
// One SCK period spans CLK_RATIO system clocks.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module spi_phase_gen #(
  parameter int CLK_RATIO = 32  // Multiple of 4
) (
  input  logic i_ext_spi_clk_x,
  input  logic i_srst,
  output logic o_sck,
  output logic o_rise,
  output logic o_fall
);

  localparam int CNT_W = $clog2(CLK_RATIO);

  logic [CNT_W-1:0] r_cnt;  // Phase within the SCK period

  // Free-running phase counter
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      r_cnt <= '0;
    end else if (r_cnt == CNT_W'(CLK_RATIO - 1)) begin
      r_cnt <= '0;
    end else begin
      r_cnt <= r_cnt + 1'b1;
    end
  end

  assign o_sck  = (r_cnt < CNT_W'(CLK_RATIO / 2));   // High in first half
  assign o_rise = (r_cnt == '0);                     // Same cycle SCK goes high
  assign o_fall = (r_cnt == CNT_W'(CLK_RATIO / 2));  // Same cycle SCK goes low

  // Edge strobes must sit at quarter points of the period
  a_ratio : assert property (@(posedge i_ext_spi_clk_x)
    (CLK_RATIO % 4) == 0) else $error("CLK_RATIO not a multiple of 4");

endmodule : spi_phase_gen

`default_nettype wire

// ==== design/spi_cmd_latch.sv ====
//////////////////////////////////////////////////
// Command holding register between system and bus.
// Takes a go only while idle, keeps it for the frame.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_latch (
  input  logic              i_ext_spi_clk_x,
  input  logic              i_srst,
  input  logic              i_go,
  input  spi_pkg::spi_cmd_t i_cmd,
  input  logic              i_taken,     // Bus machine left IDLE
  input  logic              i_bus_idle,
  output spi_pkg::spi_cmd_t o_cmd,
  output logic              o_start,
  output logic              o_idle
);

  logic w_accept;

  // Idle only with the bus parked and nothing pending
  assign o_idle   = i_bus_idle & ~o_start;
  assign w_accept = i_go & o_idle;  // Go while busy is dropped

  // Start request, held until the bus machine picks it up
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      o_start <= 1'b0;
    end else if (w_accept) begin
      o_start <= 1'b1;
    end else if (i_taken) begin
      o_start <= 1'b0;
    end
  end

  // Command fields
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (w_accept) o_cmd <= i_cmd;  // Stable through the whole frame
  end

  a_tx_len : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    w_accept |-> (i_cmd.tx_len != '0)) else $error("Go with zero tx_len");

endmodule : spi_cmd_latch

`default_nettype wire

// ==== design/spi_bus_fsm.sv ====
//////////////////////////////////////////////////
// Mode 0 frame sequencer through guards, TX, wait and RX.
// Steps on the falling strobe and samples CIPO on rise.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module spi_bus_fsm (
  input  logic                       i_ext_spi_clk_x,
  input  logic                       i_srst,
  input  spi_pkg::spi_cmd_t          i_cmd,
  input  logic                       i_start,
  input  logic                       i_sck,
  input  logic                       i_rise,
  input  logic                       i_fall,
  input  logic [spi_pkg::BYTE_W-1:0] i_tx_data,
  input  logic                       i_tx_valid,
  input  logic                       i_tx_empty,
  input  logic                       i_rx_full,
  input  logic                       i_cipo,
  output logic                       o_taken,
  output logic                       o_bus_idle,
  output logic                       o_tx_rd,
  output logic                       o_rx_wr,
  output logic [spi_pkg::BYTE_W-1:0] o_rx_data,
  output spi_pkg::spi_pins_t         o_pins
);

  localparam int TB = spi_pkg::TIMER_BITS;
  localparam int BW = spi_pkg::BYTE_W;

  spi_pkg::spi_state_e r_state;
  spi_pkg::spi_state_e w_state_nx;
  logic [TB-1:0]       r_t;          // Bit timer in SCK periods within the state
  logic [TB-1:0]       w_tx_bits;
  logic [TB-1:0]       w_rx_bits;
  logic                w_guard_done;
  logic                w_tx_last;
  logic                w_rx_last;
  logic                w_wait_last;
  logic                w_byte_end;
  logic                w_tx_fetch;   // Next fall starts a new TX byte
  logic [BW-1:0]       r_tx_sreg;
  logic                r_tx_have;    // FIFO byte waiting in i_tx_data
  logic [BW-1:0]       r_rx_sreg;

  ////////////////////////////////////////////////////
  // Timer compares
  ////////////////////////////////////////////////////
  assign w_tx_bits    = {i_cmd.tx_len, 3'b000};
  assign w_rx_bits    = {i_cmd.rx_len, 3'b000};
  assign w_guard_done = (r_t == TB'(spi_pkg::GUARD_CYC - 1));
  assign w_tx_last    = (r_t == w_tx_bits - TB'(1));
  assign w_rx_last    = (r_t == w_rx_bits - TB'(1));
  assign w_wait_last  = (r_t == TB'(i_cmd.wait_cyc) - TB'(1));
  assign w_byte_end   = (r_t[2:0] == 3'd7);

  assign w_tx_fetch = ((r_state == spi_pkg::START_S) && w_guard_done) ||
                      ((r_state == spi_pkg::TX) && w_byte_end && !w_tx_last);

  // Next state
  always_comb begin
    w_state_nx = r_state;
    case (r_state)
      spi_pkg::IDLE:    if (i_start) w_state_nx = spi_pkg::START_D;
      spi_pkg::START_D: if (w_guard_done) w_state_nx = spi_pkg::START_S;
      spi_pkg::START_S: if (w_guard_done) w_state_nx = spi_pkg::TX;
      spi_pkg::TX: begin
        if (w_tx_last) begin
          if (i_cmd.rx_len == '0) w_state_nx = spi_pkg::STOP_S;     // Write-only frame
          else if (i_cmd.wait_cyc == '0) w_state_nx = spi_pkg::RX;
          else w_state_nx = spi_pkg::WAIT;
        end
      end
      spi_pkg::WAIT:    if (w_wait_last) w_state_nx = spi_pkg::RX;
      spi_pkg::RX:      if (w_rx_last) w_state_nx = spi_pkg::STOP_S;
      spi_pkg::STOP_S:  if (w_guard_done) w_state_nx = spi_pkg::STOP_D;
      spi_pkg::STOP_D:  if (w_guard_done) w_state_nx = spi_pkg::IDLE;
      default:          w_state_nx = spi_pkg::IDLE;
    endcase
  end

  // State and timer step on the falling strobe
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      r_state <= spi_pkg::IDLE;
      r_t     <= '0;
    end else if (i_fall) begin
      r_state <= w_state_nx;
      if ((w_state_nx != r_state) || (r_state == spi_pkg::IDLE)) r_t <= '0;
      else r_t <= r_t + 1'b1;
    end
  end

  assign o_taken    = i_fall & i_start & (r_state == spi_pkg::IDLE);
  assign o_bus_idle = (r_state == spi_pkg::IDLE);

  ////////////////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////////////////
  // Prefetch on the rise before the byte boundary
  assign o_tx_rd = i_rise & w_tx_fetch & ~i_tx_empty;

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      r_tx_have <= 1'b0;
    end else if (i_tx_valid) begin
      r_tx_have <= 1'b1;
    end else if (i_fall && w_tx_fetch) begin
      r_tx_have <= 1'b0;  // Consumed by the load
    end
  end

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_fall) begin
      if (w_tx_fetch) r_tx_sreg <= r_tx_have ? i_tx_data : '0;  // Zeros on underrun
      else if (r_state == spi_pkg::TX) r_tx_sreg <= {r_tx_sreg[BW-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      o_rx_wr <= 1'b0;
    end else begin
      // Full FIFO drops the byte and the bus keeps running
      o_rx_wr <= i_rise & (r_state == spi_pkg::RX) & w_byte_end & ~i_rx_full;
    end
  end

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_rise && (r_state == spi_pkg::RX)) begin
      r_rx_sreg <= {r_rx_sreg[BW-2:0], i_cipo};  // MSB first
      if (w_byte_end) o_rx_data <= {r_rx_sreg[BW-2:0], i_cipo};
    end
  end

  // Pin drive
  always_comb begin
    o_pins.csn  = (r_state == spi_pkg::IDLE) || (r_state == spi_pkg::START_D) ||
                  (r_state == spi_pkg::STOP_D);
    o_pins.sck  = i_sck & ((r_state == spi_pkg::TX) || (r_state == spi_pkg::WAIT) ||
                           (r_state == spi_pkg::RX));  // Parked low elsewhere
    o_pins.copi = (r_state == spi_pkg::TX) ? r_tx_sreg[BW-1] : 1'b0;
  end

  // State may only move on a falling strobe with SCK already low so SCK never gets a runt
  a_fall_only : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    $changed(r_state) |-> $past(i_fall && !i_sck))
    else $error("State change off the falling strobe");

endmodule : spi_bus_fsm

`default_nettype wire

// ==== design/spi_master_top.sv ====
//////////////////////////////////////////////////
// SPI Mode 0 master with TX and RX byte FIFOs.
// System loads TX, issues a go, drains RX.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module spi_master_top #(
  parameter int CLK_RATIO  = 32,   // System clocks per SCK
  parameter int FIFO_DEPTH = 2048  // Per FIFO
) (
  input  logic                       i_ext_spi_clk_x,
  input  logic                       i_srst,
  input  logic                       i_go,
  input  spi_pkg::spi_cmd_t          i_cmd,
  input  logic [spi_pkg::BYTE_W-1:0] i_tx_data,
  input  logic                       i_tx_enqueue,
  input  logic                       i_rx_dequeue,
  input  logic                       i_cipo,
  output logic                       o_idle,
  output logic                       o_tx_ready,
  output logic [spi_pkg::BYTE_W-1:0] o_rx_data,
  output logic                       o_rx_valid,
  output logic                       o_rx_avail,
  output spi_pkg::spi_pins_t         o_pins
);

  spi_pkg::spi_cmd_t          w_cmd;
  logic                       w_start, w_taken, w_bus_idle;
  logic                       w_sck, w_rise, w_fall;
  logic [spi_pkg::BYTE_W-1:0] w_tx_data;
  logic                       w_tx_rd, w_tx_valid, w_tx_full, w_tx_empty;
  logic [spi_pkg::BYTE_W-1:0] w_rx_wr_data;
  logic                       w_rx_wr, w_rx_full, w_rx_empty;

  assign o_tx_ready = ~w_tx_full;
  assign o_rx_avail = ~w_rx_empty;

  spi_cmd_latch u_cmd_latch (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_go            (i_go),
    .i_cmd           (i_cmd),
    .i_taken         (w_taken),
    .i_bus_idle      (w_bus_idle),
    .o_cmd           (w_cmd),
    .o_start         (w_start),
    .o_idle          (o_idle)
  );

  spi_phase_gen #(.CLK_RATIO(CLK_RATIO)) u_phase_gen (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .o_sck           (w_sck),
    .o_rise          (w_rise),
    .o_fall          (w_fall)
  );

  spi_bus_fsm u_bus_fsm (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_cmd           (w_cmd),
    .i_start         (w_start),
    .i_sck           (w_sck),
    .i_rise          (w_rise),
    .i_fall          (w_fall),
    .i_tx_data       (w_tx_data),
    .i_tx_valid      (w_tx_valid),
    .i_tx_empty      (w_tx_empty),
    .i_rx_full       (w_rx_full),
    .i_cipo          (i_cipo),
    .o_taken         (w_taken),
    .o_bus_idle      (w_bus_idle),
    .o_tx_rd         (w_tx_rd),
    .o_rx_wr         (w_rx_wr),
    .o_rx_data       (w_rx_wr_data),
    .o_pins          (o_pins)
  );

  // Enqueue only counts with ready high
  sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_wr            (i_tx_enqueue & o_tx_ready),
    .i_wr_data       (i_tx_data),
    .i_rd            (w_tx_rd),
    .o_rd_data       (w_tx_data),
    .o_rd_valid      (w_tx_valid),
    .o_full          (w_tx_full),
    .o_empty         (w_tx_empty)
  );

  // Dequeue only counts with avail high
  sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_wr            (w_rx_wr),
    .i_wr_data       (w_rx_wr_data),
    .i_rd            (i_rx_dequeue & o_rx_avail),
    .o_rd_data       (o_rx_data),
    .o_rd_valid      (o_rx_valid),
    .o_full          (w_rx_full),
    .o_empty         (w_rx_empty)
  );

endmodule : spi_master_top

`default_nettype wire

// ==== test/spi_checker.sv ====
//////////////////////////////////////////////////
// Watches the SPI pins and system ports, compares
// them with the testbench model and counts errors
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module spi_checker #(
  parameter int MAX_CYCLES = 15000,  // Run limit in clocks
  parameter int FIFO_DEPTH = 16      // Depth of each DUT FIFO
) (
  input  logic               i_ext_spi_clk_x,
  input  logic               i_srst,
  input  logic               i_go,
  input  logic               i_go_expect,
  input  spi_pkg::spi_cmd_t  i_cmd,
  input  logic               i_idle,
  input  spi_pkg::spi_pins_t i_pins,
  input  logic               i_tx_ready,
  input  logic               i_rx_dequeue,
  input  logic               i_rx_avail,
  input  logic               i_rx_valid,
  input  logic [7:0]         i_rx_data,
  input  logic               i_exp_tx_push,
  input  logic               i_exp_rx_push,
  input  logic [7:0]         i_exp_byte,
  input  logic               i_frame_done,
  output int                 o_value_errs,
  output int                 o_other_errs,
  output logic               o_timeout
);

  spi_pkg::spi_cmd_t cmd_q [$];    // Accepted commands with the oldest on the bus
  logic [7:0]        tx_q  [$];    // Bytes expected on COPI
  logic [7:0]        rx_q  [$];    // Bytes expected from the RX FIFO
  spi_pkg::spi_cmd_t cur;
  logic [7:0]        exp_b;
  logic [7:0]        copi_sreg;
  logic              prev_sck, prev_csn, prev_idle;
  logic              deq_taken;    // Dequeue accepted last cycle
  logic              go_taken;     // Expected go last cycle
  int                rises;        // SCK rises in this frame
  int                exp_n;
  int                frames;
  int                accepted;
  int                last_rx_len;  // RX bytes of the frame that just closed
  int                rx_cnt;       // Model RX FIFO occupancy
  int                cycles = 0;

  assign o_timeout = (cycles >= MAX_CYCLES);

  task automatic report_mismatch(string msg);
    o_value_errs++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic note_failure(string msg);
    o_other_errs++;
    $display("Check failed at %0t ns: %s", $time, msg);
  endtask

  always @(posedge i_ext_spi_clk_x) begin
    cycles++;
    if (i_srst) begin
      cmd_q.delete();
      tx_q.delete();
      rx_q.delete();
      {prev_sck, deq_taken, go_taken} = '0;
      {prev_csn, prev_idle}           = 2'b11;
      rises       = 0;
      frames      = 0;
      accepted    = 0;
      last_rx_len = 0;
      rx_cnt      = 0;
      o_value_errs = 0;
      o_other_errs = 0;
    end else begin
      // TX FIFO holds at most the bytes not yet seen on COPI
      if (tx_q.size() < FIFO_DEPTH && i_tx_ready !== 1'b1)
        report_mismatch("o_tx_ready low with room left in the TX FIFO");
      if (i_exp_tx_push) tx_q.push_back(i_exp_byte);
      if (i_exp_rx_push) rx_q.push_back(i_exp_byte);

      ////////////////////////////////////////////////
      // Command handshake and idle
      ////////////////////////////////////////////////
      if (i_go && !i_go_expect && i_idle)
        note_failure("o_idle high in mid frame when the stray go came");
      if (i_go && i_go_expect) begin
        cmd_q.push_back(i_cmd);
        accepted++;
      end
      if (go_taken && i_idle) note_failure("o_idle still high after an accepted go");
      if (i_idle && (!i_pins.csn || i_pins.sck || i_pins.copi))
        note_failure("csn low, SCK high or COPI high while o_idle is high");
      if (i_idle && !prev_idle) frames++;     // One rise per frame

      // COPI captured MSB first on each SCK rise
      if (!i_pins.csn && i_pins.sck && !prev_sck) begin
        if (cmd_q.size() == 0) begin
          note_failure("SCK pulse with no command issued");
        end else if (rises < 8 * int'(cmd_q[0].tx_len)) begin
          copi_sreg = {copi_sreg[6:0], i_pins.copi};
          if (rises % 8 == 7) begin
            if (tx_q.size() == 0) begin
              note_failure("byte shifted out on COPI that was never enqueued");
            end else begin
              exp_b = tx_q.pop_front();
              if (copi_sreg !== exp_b)
                report_mismatch($sformatf("COPI byte %h, expected %h", copi_sreg, exp_b));
            end
          end
        end
        rises++;
      end

      // SCK count checked against the command at frame end
      if (i_pins.csn && !prev_csn) begin
        if (cmd_q.size() == 0) begin
          note_failure("chip select frame with no command issued");
        end else begin
          cur         = cmd_q.pop_front();
          last_rx_len = int'(cur.rx_len);
          exp_n = 8 * int'(cur.tx_len) + 8 * int'(cur.rx_len);
          if (cur.rx_len != '0) exp_n += int'(cur.wait_cyc);  // Wait only before RX
          if (rises != exp_n)
            report_mismatch($sformatf("%0d SCK pulses in frame, expected %0d", rises, exp_n));
        end
        rises = 0;
      end

      ////////////////////////////////////////////////
      // RX dequeue side
      ////////////////////////////////////////////////
      if (i_idle && !prev_idle) rx_cnt = last_rx_len;  // Whole frame is in the RX FIFO
      if (i_idle && (i_rx_avail !== (rx_cnt != 0)))
        report_mismatch($sformatf("o_rx_avail %b with %0d RX bytes left", i_rx_avail, rx_cnt));
      if (i_rx_dequeue && rx_cnt != 0) rx_cnt--;
      if (i_rx_valid != deq_taken)
        note_failure(i_rx_valid ? "o_rx_valid without a dequeue" :
                                  "no o_rx_valid one cycle after a dequeue");
      if (i_rx_valid) begin
        if (rx_q.size() == 0) begin
          note_failure("more RX bytes than the frame asked for");
        end else begin
          exp_b = rx_q.pop_front();
          if (i_rx_data !== exp_b)
            report_mismatch($sformatf("RX byte %h, expected %h", i_rx_data, exp_b));
        end
      end

      if (i_frame_done) begin
        if (rx_q.size() != 0) note_failure($sformatf("%0d RX bytes missing", rx_q.size()));
        if (tx_q.size() != 0) note_failure($sformatf("%0d TX bytes not sent", tx_q.size()));
        if (frames != accepted)
          note_failure($sformatf("%0d frames for %0d accepted gos", frames, accepted));
        rx_q.delete();
        tx_q.delete();
      end

      deq_taken = i_rx_dequeue && i_rx_avail;
      go_taken  = i_go && i_go_expect;
      prev_sck  = i_pins.sck;
      prev_csn  = i_pins.csn;
      prev_idle = i_idle;
    end
  end

endmodule : spi_checker

`default_nettype wire

// ==== test/tb_spi_master.sv ====
//////////////////////////////////////////////////
// Testbench for the SPI master. Random frames, a
// CIPO slave model and a checker on the DUT ports
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_spi_master;

  localparam int N_TRANS    = 20;
  localparam int LW         = spi_pkg::LEN_BITS;
  localparam int FIFO_DEPTH = 16;

  logic               clk = 1'b0;
  logic               srst;
  logic               go;
  spi_pkg::spi_cmd_t  cmd;
  logic [7:0]         tx_data;
  logic               tx_enqueue;
  logic               rx_dequeue;
  logic               cipo = 1'b0;    // Slave model output
  logic               idle;
  logic               tx_ready;
  logic               rx_valid;
  logic               rx_avail;
  logic [7:0]         rx_data;
  spi_pkg::spi_pins_t pins;

  // Model traffic into the checker
  logic       go_expect;               // High when this go must be taken
  logic       exp_tx_push;
  logic       exp_rx_push;
  logic [7:0] exp_byte;
  logic       frame_done;              // Frame sent and RX drained
  int         value_errs;
  int         other_errs;
  logic       timeout;

  // Slave model state
  logic [7:0] slave_bytes [4];         // CIPO payload of the frame
  int         slave_skip;              // TX and wait rises before payload
  int         slave_rx_bits;
  int         slave_rises = 0;
  int         slave_pos;
  logic       slave_prev_sck = 1'b0;

  always #50 clk = ~clk;  // 100 ns period

  spi_master_top #(.CLK_RATIO(8), .FIFO_DEPTH(FIFO_DEPTH)) uut (
    .i_ext_spi_clk_x (clk),
    .i_srst          (srst),
    .i_go            (go),
    .i_cmd           (cmd),
    .i_tx_data       (tx_data),
    .i_tx_enqueue    (tx_enqueue),
    .i_rx_dequeue    (rx_dequeue),
    .i_cipo          (cipo),
    .o_idle          (idle),
    .o_tx_ready      (tx_ready),
    .o_rx_data       (rx_data),
    .o_rx_valid      (rx_valid),
    .o_rx_avail      (rx_avail),
    .o_pins          (pins)
  );

  // 20 frames of at most 75 SCK periods of 8 clocks, plus load and drain
  spi_checker #(.MAX_CYCLES(15000), .FIFO_DEPTH(FIFO_DEPTH)) u_checker (
    .i_ext_spi_clk_x (clk),
    .i_srst          (srst),
    .i_go            (go),
    .i_go_expect     (go_expect),
    .i_cmd           (cmd),
    .i_idle          (idle),
    .i_pins          (pins),
    .i_tx_ready      (tx_ready),
    .i_rx_dequeue    (rx_dequeue),
    .i_rx_avail      (rx_avail),
    .i_rx_valid      (rx_valid),
    .i_rx_data       (rx_data),
    .i_exp_tx_push   (exp_tx_push),
    .i_exp_rx_push   (exp_rx_push),
    .i_exp_byte      (exp_byte),
    .i_frame_done    (frame_done),
    .o_value_errs    (value_errs),
    .o_other_errs    (other_errs),
    .o_timeout       (timeout)
  );

  ////////////////////////////////////////////////////
  // New CIPO bit from the slave model after each SCK fall
  ////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (pins.csn) begin
      slave_rises = 0;                           // Between frames
    end else if (!slave_prev_sck && pins.sck) begin
      slave_rises++;
    end else if (slave_prev_sck && !pins.sck) begin
      slave_pos = slave_rises - slave_skip;      // Index of the next rise in payload
      if (slave_pos >= 0 && slave_pos < slave_rx_bits)
        cipo = slave_bytes[slave_pos / 8][7 - (slave_pos % 8)];  // MSB first
      else
        cipo = 1'($urandom);                     // Noise outside the RX window
    end
    slave_prev_sck = pins.sck;
  end

  // Loads TX, issues a go and a stray go, waits for the end and drains RX
  task automatic run_frame();
    int tx_len;
    int rx_len;
    int wait_cyc;
    tx_len   = 1 + ($urandom % 4);
    rx_len   = $urandom % 5;
    wait_cyc = $urandom % 4;
    for (int i = 0; i < tx_len; i++) begin
      @(negedge clk);
      while (!tx_ready) @(negedge clk);
      tx_data     = 8'($urandom);
      tx_enqueue  = 1'b1;
      exp_tx_push = 1'b1;
      exp_byte    = tx_data;
    end
    @(negedge clk);
    tx_enqueue  = 1'b0;
    exp_tx_push = 1'b0;
    for (int i = 0; i < rx_len; i++) slave_bytes[i] = 8'($urandom);
    slave_skip    = 8 * tx_len + ((rx_len != 0) ? wait_cyc : 0);
    slave_rx_bits = 8 * rx_len;
    while (!idle) @(negedge clk);
    cmd.tx_len   = LW'(tx_len);
    cmd.wait_cyc = 2'(wait_cyc);
    cmd.rx_len   = LW'(rx_len);
    go           = 1'b1;
    go_expect    = 1'b1;
    @(negedge clk);
    go        = 1'b0;
    go_expect = 1'b0;
    repeat (20) @(negedge clk);
    cmd        = 24'($urandom);                  // Junk go in mid frame
    cmd.tx_len = LW'(1);
    go         = 1'b1;
    @(negedge clk);
    go = 1'b0;
    while (!idle) @(negedge clk);
    for (int i = 0; i < rx_len; i++) begin
      exp_rx_push = 1'b1;
      exp_byte    = slave_bytes[i];
      @(negedge clk);
    end
    exp_rx_push = 1'b0;
    while (rx_avail) begin
      rx_dequeue = 1'($urandom);                 // Throttled drain
      @(negedge clk);
    end
    rx_dequeue = 1'b0;
    repeat (2) @(negedge clk);
    frame_done = 1'b1;
    @(negedge clk);
    frame_done = 1'b0;
  endtask

  initial begin
    int seed_sink;
    seed_sink   = $urandom(32'hbe41_be84);
    srst        = 1'b1;
    go          = 1'b0;
    cmd         = '0;
    tx_data     = '0;
    tx_enqueue  = 1'b0;
    rx_dequeue  = 1'b0;
    go_expect   = 1'b0;
    exp_tx_push = 1'b0;
    exp_rx_push = 1'b0;
    exp_byte    = '0;
    frame_done  = 1'b0;
    slave_skip    = 0;
    slave_rx_bits = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    srst = 1'b0;
    for (int t = 0; t < N_TRANS; t++) run_frame();
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // Hang guard
  always @(posedge clk) begin
    if (timeout) begin
      $display("Timeout: the run did not finish within the cycle limit");
      $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule : tb_spi_master

`default_nettype wire

// ==== verilog.f ====
design/spi_pkg.sv
design/sync_fifo.sv
design/spi_phase_gen.sv
design/spi_cmd_latch.sv
design/spi_bus_fsm.sv
design/spi_master_top.sv
test/spi_checker.sv
test/tb_spi_master.sv

// ==== Makefile ====
# Verilator build and run for the SPI master testbench
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_spi_master
FILELIST := verilog.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))
PASS_MSG := *** TEST PASSED ***

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
